// File: source/st_source_pkg.sv
/* streaming source package
   bus widths, queue sizing and the transaction, beat, bus and response types */
package st_source_pkg;

   // --------------------
   // beat geometry
   // --------------------
   localparam int SYMBOL_W    = 8;
   localparam int NUM_SYMBOLS = 4;
   localparam int DATA_W      = SYMBOL_W * NUM_SYMBOLS;
   localparam int CHANNEL_W   = 4;
   // lanes packed into one bus cycle
   localparam int BEATS       = 2;
   // lane index width, wide enough to hold a lane count of 0 to BEATS
   localparam int LANE_W      = $clog2(BEATS + 1);

   // --------------------
   // timing and sizing
   // --------------------
   localparam int READY_LATENCY = 1;
   localparam int QUEUE_DEPTH   = 16;
   localparam int PTR_W         = $clog2(QUEUE_DEPTH);
   // one extra bit so a full queue is representable
   localparam int CNT_W         = $clog2(QUEUE_DEPTH + 1);
   localparam int IDLE_W        = 8;
   localparam int LAT_W         = 16;

   // --------------------
   // types
   // --------------------
   // one queued transaction
   typedef struct packed {
      logic [IDLE_W-1:0]    idles;
      logic                 sop;
      logic                 eop;
      logic [CHANNEL_W-1:0] channel;
      logic [DATA_W-1:0]    data;
   } st_txn_t;

   // one lane of a bus cycle
   typedef struct packed {
      logic                 valid;
      logic                 sop;
      logic                 eop;
      logic [CHANNEL_W-1:0] channel;
      logic [DATA_W-1:0]    data;
   } st_beat_t;

   // source bus with lane 0 in the low bits
   typedef struct packed {
      logic [BEATS-1:0]           valid;
      logic [BEATS-1:0]           sop;
      logic [BEATS-1:0]           eop;
      logic [BEATS*CHANNEL_W-1:0] channel;
      logic [BEATS*DATA_W-1:0]    data;
   } st_bus_t;

   // back-pressure report for one accepted cycle
   typedef struct packed {
      logic [LAT_W-1:0] latency;
      logic [LAT_W-1:0] count;
   } st_resp_t;

   // value on the payload fields while a beat is not shown
   typedef enum logic {
      IDLE_LOW  = 1'b0,
      IDLE_HIGH = 1'b1
   } st_idle_mode_e;

endpackage

// File: source/transaction_fifo.sv
`timescale 1ns/1ps
/* transaction queue
   circular buffer that shows a window of BEATS head entries and pops several at once */
module transaction_fifo (
   input  logic                                             clk,
   input  logic                                             reset,
   input  logic                                             push,
   input  st_source_pkg::st_txn_t                           push_txn,
   input  logic [st_source_pkg::LANE_W-1:0]                 pop_count,
   input  logic                                             head_idles_dec,
   output st_source_pkg::st_txn_t [st_source_pkg::BEATS-1:0] head_txn,
   output logic [st_source_pkg::CNT_W-1:0]                  count,
   output logic                                             full
);
   import st_source_pkg::*;

   st_txn_t          mem [QUEUE_DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] dec_ptr;
   logic             wr_en;

   assign full  = (count == CNT_W'(QUEUE_DEPTH));
   // push is dropped while full
   assign wr_en = push && !full;

   // first entry left after this cycle's pops
   // this is the one that stopped the fill
   assign dec_ptr = rd_ptr + PTR_W'(pop_count);

   // --------------------
   // pointers and count
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         // depth is a power of two so pointers wrap on their own
         wr_ptr <= wr_ptr + PTR_W'(wr_en);
         rd_ptr <= rd_ptr + PTR_W'(pop_count);
         count  <= count + CNT_W'(wr_en) - CNT_W'(pop_count);
      end
   end

   // --------------------
   // storage
   // --------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= push_txn;
      end
      // idle count runs down in place
      // never the write slot since that entry is occupied
      if (head_idles_dec) begin
         mem[dec_ptr].idles <= mem[dec_ptr].idles - 1'b1;
      end
   end

   // head window, entries past count are stale and masked downstream
   always_comb begin
      for (int i = 0; i < BEATS; i++) begin
         head_txn[i] = mem[rd_ptr + PTR_W'(i)];
      end
   end

endmodule

// File: source/beat_dispatcher.sv
`timescale 1ns/1ps
/* beat dispatcher
   packs head entries into lanes, stops at an idling entry and counts its idles down */
module beat_dispatcher (
   input  logic                                              clk,
   input  logic                                              reset,
   input  logic                                              advance,
   input  st_source_pkg::st_txn_t [st_source_pkg::BEATS-1:0]  head_txn,
   input  logic [st_source_pkg::CNT_W-1:0]                   count,
   output logic [st_source_pkg::LANE_W-1:0]                  pop_count,
   output logic                                              head_idles_dec,
   output logic                                              load,
   output st_source_pkg::st_beat_t [st_source_pkg::BEATS-1:0] lane_txn
);
   import st_source_pkg::*;

   logic                  fill;
   logic                  stop;
   st_beat_t [BEATS-1:0]  beat_c;

   // a new bus cycle is built when the tracker frees the lanes
   assign fill = advance && (count != '0);

   // --------------------
   // packing
   // --------------------
   always_comb begin
      pop_count      = '0;
      head_idles_dec = 1'b0;
      stop           = 1'b0;
      beat_c         = '0;
      for (int i = 0; i < BEATS; i++) begin
         // only real entries, lanes past the window stay invalid
         if (fill && !stop && (CNT_W'(i) < count)) begin
            if (head_txn[i].idles != '0) begin
               // idling entry burns this lane as a bubble
               // it stays queued and the rest of the cycle is empty
               head_idles_dec = 1'b1;
               stop           = 1'b1;
            end else begin
               beat_c[i].valid   = 1'b1;
               beat_c[i].sop     = head_txn[i].sop;
               beat_c[i].eop     = head_txn[i].eop;
               beat_c[i].channel = head_txn[i].channel;
               beat_c[i].data    = head_txn[i].data;
               pop_count         = pop_count + 1'b1;
            end
         end
      end
   end

   // --------------------
   // load strobe
   // --------------------
   // one cycle wide, lanes take lane_txn while it is high
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         load <= 1'b0;
      end else begin
         load <= fill;
      end
   end

   // packed lanes for the load cycle
   always_ff @(posedge clk) begin
      lane_txn <= beat_c;
   end

endmodule

// File: source/beat_lane.sv
`timescale 1ns/1ps
/* beat lane
   holds one lane's beat between loads and drives the idle pattern when it is not shown */
module beat_lane (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         load,
   input  st_source_pkg::st_beat_t      lane_txn,
   input  logic                         show,
   input  st_source_pkg::st_idle_mode_e idle_config,
   output st_source_pkg::st_beat_t      lane_out
);
   import st_source_pkg::*;

   st_beat_t beat_q;
   st_beat_t beat;
   st_beat_t beat_d;

   // a fresh beat is live in its load cycle
   assign beat = load ? lane_txn : beat_q;

   always_comb begin
      beat_d = beat;
      // once shown the beat is consumed
      beat_d.valid = beat.valid && !show;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beat_q <= '0;
      end else begin
         beat_q <= beat_d;
      end
   end

   // idle pattern on every field, valid always low
   always_comb begin
      if (show && beat.valid) begin
         lane_out = beat;
      end else if (idle_config == IDLE_HIGH) begin
         lane_out       = '1;
         lane_out.valid = 1'b0;
      end else begin
         lane_out = '0;
      end
   end

endmodule

// File: source/ready_tracker.sv
`timescale 1ns/1ps
/* ready tracker
   qualifies ready, tracks the pending cycle and its latency, builds the bus and status */
module ready_tracker (
   input  logic                                              clk,
   input  logic                                              reset,
   input  logic                                              ready,
   input  st_source_pkg::st_beat_t [st_source_pkg::BEATS-1:0] lane_out,
   input  logic                                              load,
   input  logic [st_source_pkg::CNT_W-1:0]                   count,
   output logic                                              show,
   output logic                                              advance,
   output st_source_pkg::st_bus_t                            src,
   output logic                                              resp_valid,
   output st_source_pkg::st_resp_t                           resp,
   output logic                                              complete
);
   import st_source_pkg::*;

   logic             ready_q;
   logic             pending_q;
   logic             pending;
   logic             accepted;
   logic [LAT_W-1:0] lat_q;
   logic [LAT_W-1:0] resp_cnt_q;

   // --------------------
   // ready qualification
   // --------------------
   generate
      if (READY_LATENCY == 0) begin : g_no_delay
         assign ready_q = ready;
      end else begin : g_delay
         logic [READY_LATENCY-1:0] ready_pipe;

         always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
               ready_pipe <= '0;
            end else begin
               ready_pipe <= (ready_pipe << 1) | READY_LATENCY'(ready);
            end
         end
         assign ready_q = ready_pipe[READY_LATENCY-1];
      end
   endgenerate

   assign show = ready_q;

   // load counts as pending in its own cycle
   assign pending  = pending_q || load;
   assign accepted = pending && ready_q;
   assign advance  = !pending || accepted;

   // bus assembly, lane 0 in the low bits
   always_comb begin
      src = '0;
      for (int i = 0; i < BEATS; i++) begin
         src.valid[i]                          = lane_out[i].valid;
         src.sop[i]                            = lane_out[i].sop;
         src.eop[i]                            = lane_out[i].eop;
         src.channel[i*CHANNEL_W +: CHANNEL_W] = lane_out[i].channel;
         src.data[i*DATA_W +: DATA_W]          = lane_out[i].data;
      end
   end

   // bubble-only cycles get no response
   assign resp_valid   = accepted && (src.valid != '0);
   assign resp.latency = lat_q;
   assign resp.count   = resp_cnt_q;

   // --------------------
   // pending, latency and status
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pending_q  <= 1'b0;
         lat_q      <= '0;
         resp_cnt_q <= '0;
         complete   <= 1'b0;
      end else begin
         pending_q <= pending && !ready_q;
         // back-pressure cycles since the load
         if (pending && !ready_q) begin
            lat_q <= lat_q + 1'b1;
         end else begin
            lat_q <= '0;
         end
         if (resp_valid) begin
            resp_cnt_q <= resp_cnt_q + 1'b1;
         end
         // last beats gone with nothing queued behind them
         if (resp_valid && (count == '0)) begin
            complete <= 1'b1;
         end else if (count != '0) begin
            complete <= 1'b0;
         end
      end
   end

endmodule

// File: source/st_source.sv
`timescale 1ns/1ps
/* streaming packet source
   queue and dispatcher feed BEATS lanes and the ready tracker drains them onto the bus */
module st_source (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         push,
   input  st_source_pkg::st_txn_t       push_txn,
   output logic                         full,
   input  st_source_pkg::st_idle_mode_e idle_config,
   input  logic                         ready,
   output st_source_pkg::st_bus_t       src,
   output logic                         resp_valid,
   output st_source_pkg::st_resp_t      resp,
   output logic                         complete
);
   import st_source_pkg::*;

   st_txn_t [BEATS-1:0]  head_txn;
   logic [CNT_W-1:0]     count;
   logic [LANE_W-1:0]    pop_count;
   logic                 head_idles_dec;
   logic                 advance;
   logic                 load;
   logic                 show;
   st_beat_t [BEATS-1:0] lane_txn;
   st_beat_t [BEATS-1:0] lane_out;

   // --------------------
   // feeder
   // --------------------
   transaction_fifo fifo_i (
      .clk            (clk),
      .reset          (reset),
      .push           (push),
      .push_txn       (push_txn),
      .pop_count      (pop_count),
      .head_idles_dec (head_idles_dec),
      .head_txn       (head_txn),
      .count          (count),
      .full           (full)
   );

   beat_dispatcher dispatcher_i (
      .clk            (clk),
      .reset          (reset),
      .advance        (advance),
      .head_txn       (head_txn),
      .count          (count),
      .pop_count      (pop_count),
      .head_idles_dec (head_idles_dec),
      .load           (load),
      .lane_txn       (lane_txn)
   );

   // one lane per beat of the bus cycle
   generate
      for (genvar i = 0; i < BEATS; i++) begin : g_lane
         beat_lane lane_i (
            .clk         (clk),
            .reset       (reset),
            .load        (load),
            .lane_txn    (lane_txn[i]),
            .show        (show),
            .idle_config (idle_config),
            .lane_out    (lane_out[i])
         );
      end
   endgenerate

   // --------------------
   // drain
   // --------------------
   ready_tracker tracker_i (
      .clk        (clk),
      .reset      (reset),
      .ready      (ready),
      .lane_out   (lane_out),
      .load       (load),
      .count      (count),
      .show       (show),
      .advance    (advance),
      .src        (src),
      .resp_valid (resp_valid),
      .resp       (resp),
      .complete   (complete)
   );

endmodule

// File: testbench/st_source_properties.sv
`timescale 1ns/1ps
/* source bus properties
   bound to the top level, checks ready gating, response framing and the drained state */
module st_source_properties (
   input logic                   clk,
   input logic                   reset,
   input logic                   ready,
   input st_source_pkg::st_bus_t src,
   input logic                   resp_valid,
   input logic                   complete
);
   import st_source_pkg::*;

   // --------------------
   // bus gating
   // --------------------
   // a beat only shows once ready has come through the latency
   valid_needs_ready: assert property (
      @(posedge clk) disable iff (reset)
      (src.valid != '0) |-> $past(ready, READY_LATENCY)
   ) else $error("src valid without a delayed ready");

   // a response pulse always frames at least one shown beat
   resp_needs_beat: assert property (
      @(posedge clk) disable iff (reset)
      resp_valid |-> (src.valid != '0)
   ) else $error("resp_valid without a valid src beat");

   // drained source keeps the bus empty
   quiet_when_complete: assert property (
      @(posedge clk) disable iff (reset)
      complete |-> (src.valid == '0)
   ) else $error("src valid while complete is high");

endmodule

bind st_source st_source_properties props_i (
   .clk        (clk),
   .reset      (reset),
   .ready      (ready),
   .src        (src),
   .resp_valid (resp_valid),
   .complete   (complete)
);

// File: testbench/st_source_tb.sv
`timescale 1ns/1ps
/* streaming source testbench
   file-driven pushes, random ready and a cycle model of the packing and ready rules */
module st_source_tb;
   import st_source_pkg::*;

   localparam int MAX_TXN    = 64;
   localparam int WAIT_LIMIT = 400;

   logic          clk;
   logic          reset;
   logic          push;
   st_txn_t       push_txn;
   logic          full;
   st_idle_mode_e idle_config;
   logic          ready;
   st_bus_t       src;
   logic          resp_valid;
   st_resp_t      resp;
   logic          complete;

   integer seed = 32'h9a48;

   // stimulus from the file
   st_txn_t       txn_list [MAX_TXN];
   st_idle_mode_e mode_list [MAX_TXN];
   logic          gap_list [MAX_TXN];
   st_beat_t      exp_order [MAX_TXN];
   int            n_txn;
   int            beats_seen;

   // reference model state
   st_txn_t              mq[$];
   logic                 rdy_hist[$];
   st_beat_t [BEATS-1:0] m_lanes;
   logic                 m_load;
   logic                 m_pend_q;
   logic                 m_complete;
   logic [LAT_W-1:0]     m_lat;
   logic [LAT_W-1:0]     m_cnt;

   st_source dut_i (
      .clk         (clk),
      .reset       (reset),
      .push        (push),
      .push_txn    (push_txn),
      .full        (full),
      .idle_config (idle_config),
      .ready       (ready),
      .src         (src),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .complete    (complete)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // --------------------
   // reporting and compares
   // --------------------
   task automatic stop_run();
      $display("TB FAILED");
      $fatal(1, "stopping on the first error");
   endtask

   task automatic report_mismatch(input string msg);
      $display("Mismatch at time %0d ns: %s", $time, msg);
      stop_run();
   endtask

   task automatic check_beat(input st_beat_t got, input st_beat_t exp, input string what);
      if (got !== exp) begin
         report_mismatch($sformatf("%s beat got %h expected %h", what, got, exp));
      end
   endtask

   task automatic check_resp(input st_resp_t got, input st_resp_t exp);
      if (got !== exp) begin
         report_mismatch($sformatf("resp latency %0d count %0d expected latency %0d count %0d",
                                   got.latency, got.count, exp.latency, exp.count));
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
      end
   endtask

   // --------------------
   // model helpers
   // --------------------
   function automatic st_beat_t lane_from_bus(input st_bus_t bus, input int i);
      st_beat_t b;
      b.valid   = bus.valid[i];
      b.sop     = bus.sop[i];
      b.eop     = bus.eop[i];
      b.channel = bus.channel[i*CHANNEL_W +: CHANNEL_W];
      b.data    = bus.data[i*DATA_W +: DATA_W];
      return b;
   endfunction

   function automatic st_beat_t beat_of_txn(input st_txn_t t);
      st_beat_t b;
      b.valid   = 1'b1;
      b.sop     = t.sop;
      b.eop     = t.eop;
      b.channel = t.channel;
      b.data    = t.data;
      return b;
   endfunction

   // hidden lane shows every field at the idle level and valid low
   function automatic st_beat_t idle_beat(input st_idle_mode_e mode);
      st_beat_t b;
      if (mode == IDLE_HIGH) begin
         b = '1;
      end else begin
         b = '0;
      end
      b.valid = 1'b0;
      return b;
   endfunction

   // one clock of the model that compares this cycle and then steps past the next edge
   task automatic step_model();
      st_beat_t             got;
      st_beat_t             exp;
      st_resp_t             exp_resp;
      st_txn_t              head;
      st_beat_t [BEATS-1:0] fill_lanes;
      logic                 rq;
      logic                 pend;
      logic                 acc;
      logic                 shown_any;
      logic                 stop;
      int                   depth;
      int                   npop;
      rq        = rdy_hist[0];
      pend      = m_pend_q || m_load;
      acc       = pend && rq;
      shown_any = 1'b0;
      depth     = mq.size();
      for (int i = 0; i < BEATS; i++) begin
         got = lane_from_bus(src, i);
         if (acc && m_lanes[i].valid) begin
            exp       = m_lanes[i];
            shown_any = 1'b1;
         end else begin
            exp = idle_beat(idle_config);
         end
         check_beat(got, exp, $sformatf("lane %0d", i));
         // push order across lanes with lane 0 first
         if (got.valid) begin
            check_beat(got, exp_order[beats_seen], $sformatf("file order %0d", beats_seen));
            beats_seen++;
         end
      end
      check_bit(resp_valid, shown_any, "resp_valid");
      if (shown_any) begin
         exp_resp.latency = m_lat;
         exp_resp.count   = m_cnt;
         check_resp(resp, exp_resp);
      end
      check_bit(complete, m_complete, "complete");
      check_bit(full, depth == QUEUE_DEPTH, "full");

      // status after the edge
      if (shown_any && depth == 0) begin
         m_complete = 1'b1;
      end else if (depth != 0) begin
         m_complete = 1'b0;
      end
      if (shown_any) begin
         m_cnt = m_cnt + LAT_W'(1);
      end
      if (pend && !rq) begin
         m_lat = m_lat + LAT_W'(1);
      end else begin
         m_lat = '0;
      end
      m_pend_q = pend && !rq;

      // new bus cycle once the lanes are free
      m_load     = (!pend || acc) && (depth != 0);
      fill_lanes = '0;
      npop       = 0;
      stop       = 1'b0;
      for (int i = 0; i < BEATS; i++) begin
         if (m_load && !stop && i < depth) begin
            head = mq[i];
            if (head.idles != '0) begin
               // bubble lane while the entry stays at the head
               head.idles = head.idles - IDLE_W'(1);
               mq[i]      = head;
               stop       = 1'b1;
            end else begin
               fill_lanes[i] = beat_of_txn(head);
               npop++;
            end
         end
      end
      if (m_load) begin
         m_lanes = fill_lanes;
      end
      repeat (npop) void'(mq.pop_front());
      if (push && depth < QUEUE_DEPTH) begin
         mq.push_back(push_txn);
      end
      rdy_hist.push_back(ready);
      void'(rdy_hist.pop_front());
   endtask

   always @(negedge clk) begin
      if (!reset) begin
         step_model();
      end
   end

   // --------------------
   // waits
   // --------------------
   task automatic wait_not_full();
      int waited;
      waited = 0;
      while (full) begin
         if (waited >= WAIT_LIMIT) begin
            $display("timeout: queue stayed full for %0d cycles", WAIT_LIMIT);
            stop_run();
         end
         @(posedge clk);
         #2;
         waited++;
      end
   endtask

   // all pushed beats seen and the source reports complete
   task automatic wait_for_drain(input int expected_beats);
      int waited;
      waited = 0;
      while (!(complete && beats_seen == expected_beats)) begin
         if (waited >= WAIT_LIMIT) begin
            $display("timeout: queue did not drain within %0d cycles", WAIT_LIMIT);
            stop_run();
         end
         @(posedge clk);
         #2;
         waited++;
      end
   endtask

   task automatic read_stimulus();
      int                fd;
      int                fields;
      int                mode;
      int                ord;
      int                gap;
      int                idl;
      int                sop;
      int                eop;
      int                ch;
      logic [DATA_W-1:0] dat;
      string             line;
      st_txn_t           t;
      fd = $fopen("testbench/stimulus_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open testbench/stimulus_input.txt");
         stop_run();
      end
      n_txn = 0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         // skip column notes and blank lines
         if (line.len() > 1 && line[0] != "#") begin
            fields = $sscanf(line, "%d %d %d %d %h %h %h %h",
                             mode, ord, gap, idl, sop, eop, ch, dat);
            if (fields != 8 || ord < 0 || ord >= MAX_TXN || n_txn >= MAX_TXN) begin
               $display("bad stimulus line: %s", line);
               stop_run();
            end
            t.idles          = IDLE_W'(idl);
            t.sop            = sop[0];
            t.eop            = eop[0];
            t.channel        = CHANNEL_W'(ch);
            t.data           = dat;
            txn_list[n_txn]  = t;
            mode_list[n_txn] = st_idle_mode_e'(mode[0]);
            gap_list[n_txn]  = gap[0];
            exp_order[ord]   = beat_of_txn(t);
            n_txn++;
         end
      end
      $fclose(fd);
   endtask

   // --------------------
   // stimulus
   // --------------------
   // sink ready high three cycles in four on average
   initial begin
      forever begin
         @(posedge clk);
         #2;
         ready = (($random(seed) & 3) != 0);
      end
   end

   initial begin
      reset       = 1'b1;
      push        = 1'b0;
      push_txn    = '0;
      idle_config = IDLE_LOW;
      ready       = 1'b0;
      beats_seen  = 0;
      m_lanes     = '0;
      m_load      = 1'b0;
      m_pend_q    = 1'b0;
      m_complete  = 1'b0;
      m_lat       = '0;
      m_cnt       = '0;
      for (int i = 0; i < READY_LATENCY; i++) begin
         rdy_hist.push_back(1'b0);
      end
      read_stimulus();
      if (n_txn == 0) begin
         $display("stimulus file holds no transactions");
         stop_run();
      end

      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;

      for (int k = 0; k < n_txn; k++) begin
         // gap lines let the source go complete first
         if (gap_list[k]) begin
            wait_for_drain(k);
         end
         wait_not_full();
         push        = 1'b1;
         push_txn    = txn_list[k];
         idle_config = mode_list[k];
         @(posedge clk);
         #2;
         push = 1'b0;
      end
      wait_for_drain(n_txn);

      $display("TB PASSED");
      $finish;
   end

endmodule

// File: verilog.f
source/st_source_pkg.sv
source/transaction_fifo.sv
source/beat_dispatcher.sv
source/beat_lane.sv
source/ready_tracker.sv
source/st_source.sv
testbench/st_source_properties.sv
testbench/st_source_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the design and testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
   --top-module st_source_tb -f verilog.f -o st_source_sim &&
   ./obj_dir/st_source_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: testbench/stimulus_input.txt
# mode order gap idles sop eop channel data
# mode 0 idle low, 1 idle high; gap 1 drains the queue before the push; idles decimal, rest hex
0 0 0 0 1 0 3 a0000001
0 1 0 0 0 0 3 a0000002
0 2 0 2 0 0 3 a0000003
0 3 0 0 0 1 3 a0000004
0 4 0 1 1 1 5 b0000001
0 5 0 0 1 0 7 c0000001
0 6 0 0 0 0 7 c0000002
0 7 0 3 0 1 7 c0000003
1 8 1 0 1 0 2 d0000001
1 9 0 0 0 0 2 d0000002
1 10 0 1 0 0 2 d0000003
1 11 0 0 0 1 2 d0000004
1 12 0 0 1 1 f ffffffff
1 13 0 2 1 0 9 e0000001
1 14 0 0 0 1 9 e0000002
0 15 1 0 1 0 1 00000000
0 16 0 0 0 0 1 12345678
0 17 0 4 0 0 1 9abcdef0
0 18 0 0 0 1 1 0f0f0f0f
1 19 0 0 1 0 4 55aa55aa
1 20 0 1 0 0 4 aa55aa55
1 21 0 0 0 1 4 3c3c3c3c
